/* logic/mdu_config.svh */
/* Width macros for the multiply/divide unit: operand width, word width
   and destination tag width. */
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// Operand and result width of the core.
`define MDU_XLEN 64

// Width used by the W-suffixed word operations.
`define MDU_WLEN 32

// Destination register tag carried alongside each operation.
`define MDU_TAG_W 5

`endif

/* logic/mdu_pkg.sv */
/* Types shared by the multiply/divide unit: operation and state enums,
   request, operand and response structs. */
`default_nettype none

`include "mdu_config.svh"

package mdu_pkg;

    // The thirteen RV64M operations.
    typedef enum logic [3:0] {
        OP_MUL    = 4'd0,
        OP_MULH   = 4'd1,
        OP_MULHSU = 4'd2,
        OP_MULHU  = 4'd3,
        OP_MULW   = 4'd4,
        OP_DIV    = 4'd5,
        OP_DIVU   = 4'd6,
        OP_DIVW   = 4'd7,
        OP_DIVUW  = 4'd8,
        OP_REM    = 4'd9,
        OP_REMU   = 4'd10,
        OP_REMW   = 4'd11,
        OP_REMUW  = 4'd12
    } mdu_op_e;

    // Controller states of mdu_top.
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        PREP    = 3'd1,
        RUN_MUL = 3'd2,
        RUN_DIV = 3'd3,
        FORMAT  = 3'd4,
        RESPOND = 3'd5
    } mdu_state_e;

    typedef struct packed {
        mdu_op_e                op;
        logic [`MDU_XLEN-1:0]   rs1;
        logic [`MDU_XLEN-1:0]   rs2;
        logic [`MDU_TAG_W-1:0]  tag;
    } mdu_req_t;

    // Magnitudes and flags that the cores and the formatter work from.
    typedef struct packed {
        logic [`MDU_XLEN-1:0]   mag_a;
        logic [`MDU_XLEN-1:0]   mag_b;
        logic                   neg_lo;
        logic                   neg_rem;
        logic                   div_zero;
        logic                   div_ovf;
        logic                   word;
    } mdu_operands_t;

    typedef struct packed {
        logic [`MDU_XLEN-1:0]   result;
        logic [`MDU_TAG_W-1:0]  tag;
    } mdu_rsp_t;

endpackage

`default_nettype wire

/* logic/mdu_operand_prep.sv */
/* Operand preparation: signedness per operation, word truncation,
   absolute values, result sign flags and division special cases. */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_operand_prep import mdu_pkg::*; (
    input  wire mdu_req_t req,
    output mdu_operands_t opnd
);

    localparam int XLEN = `MDU_XLEN;
    localparam int WLEN = `MDU_WLEN;

    logic            sgn_a;
    logic            sgn_b;
    logic            word;
    logic            is_div;
    logic [XLEN-1:0] a_ext;
    logic [XLEN-1:0] b_ext;
    logic [XLEN-1:0] min_val;
    logic            neg_a;
    logic            neg_b;

    // Decode signed treatment of each operand, word width and divide class.
    always_comb begin
        sgn_a  = 1'b0;
        sgn_b  = 1'b0;
        word   = 1'b0;
        is_div = 1'b0;
        unique case (req.op)
            OP_MUL, OP_MULH: begin
                sgn_a = 1'b1;
                sgn_b = 1'b1;
            end
            OP_MULHSU:          sgn_a = 1'b1;
            OP_MULHU:           ;
            OP_MULW:            word = 1'b1;
            OP_DIV, OP_REM: begin
                sgn_a  = 1'b1;
                sgn_b  = 1'b1;
                is_div = 1'b1;
            end
            OP_DIVU, OP_REMU:   is_div = 1'b1;
            OP_DIVW, OP_REMW: begin
                sgn_a  = 1'b1;
                sgn_b  = 1'b1;
                word   = 1'b1;
                is_div = 1'b1;
            end
            OP_DIVUW, OP_REMUW: begin
                word   = 1'b1;
                is_div = 1'b1;
            end
            default:            ;
        endcase
    end

    // Word operations see only the low half, extended by signedness.
    always_comb begin
        if (word) begin
            a_ext = {{(XLEN-WLEN){sgn_a & req.rs1[WLEN-1]}}, req.rs1[WLEN-1:0]};
            b_ext = {{(XLEN-WLEN){sgn_b & req.rs2[WLEN-1]}}, req.rs2[WLEN-1:0]};
            min_val = {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}};
        end else begin
            a_ext = req.rs1;
            b_ext = req.rs2;
            min_val = {1'b1, {(XLEN-1){1'b0}}};
        end
    end

    assign neg_a = sgn_a & a_ext[XLEN-1];
    assign neg_b = sgn_b & b_ext[XLEN-1];

    assign opnd.mag_a    = neg_a ? (~a_ext + 1'b1) : a_ext;
    assign opnd.mag_b    = neg_b ? (~b_ext + 1'b1) : b_ext;
    // MULHSU never flags rs2 as negative, so the XOR reduces to the sign of rs1.
    assign opnd.neg_lo   = neg_a ^ neg_b;
    // A remainder follows the sign of the dividend only.
    assign opnd.neg_rem  = neg_a;
    assign opnd.div_zero = is_div & (b_ext == '0);
    assign opnd.div_ovf  = is_div & sgn_a & (a_ext == min_val) & (b_ext == '1);
    assign opnd.word     = word;

endmodule

`default_nettype wire

/* logic/mdu_div_core.sv */
/* Iterative restoring divider on unsigned magnitudes, one quotient bit
   per cycle, 64 or 32 iterations. */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_div_core (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 start,
    input  wire logic [`MDU_XLEN-1:0] mag_a,
    input  wire logic [`MDU_XLEN-1:0] mag_b,
    input  wire logic                 word,
    output logic [`MDU_XLEN-1:0]      quot,
    output logic [`MDU_XLEN-1:0]      rem,
    output logic                      done
);

    localparam int XLEN  = `MDU_XLEN;
    localparam int WLEN  = `MDU_WLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    // Upper half is the partial remainder, lower half shifts the dividend
    // out and the quotient in.
    logic [2*XLEN-1:0] pr;
    logic [XLEN-1:0]   divisor;

    logic [XLEN:0]     trial;
    logic              fits;
    logic [XLEN:0]     diff;
    logic [2*XLEN-1:0] pr_next;

    // One restoring step: shift left, then subtract if the divisor fits.
    always_comb begin
        trial = pr[2*XLEN-1:XLEN-1];
        fits  = (trial >= {1'b0, divisor});
        diff  = trial - {1'b0, divisor};
        if (fits) begin
            pr_next = {diff[XLEN-1:0], pr[XLEN-2:0], 1'b1};
        end else begin
            pr_next = {pr[2*XLEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= word ? CNT_W'(WLEN) : CNT_W'(XLEN);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Word dividends are left-aligned so that their top bit is consumed first.
    always_ff @(posedge clk) begin
        if (start) begin
            pr      <= {{XLEN{1'b0}},
                        word ? {mag_a[WLEN-1:0], {(XLEN-WLEN){1'b0}}} : mag_a};
            divisor <= mag_b;
        end else if (busy) begin
            pr <= pr_next;
        end
    end

    assign quot = pr[XLEN-1:0];
    assign rem  = pr[2*XLEN-1:XLEN];

    // The controller must wait for done before it starts another division.
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset) start |-> !busy
    );

endmodule

`default_nettype wire

/* logic/mdu_mul_core.sv */
/* Iterative shift-add multiplier on unsigned magnitudes, producing the
   double-width product over 64 or 32 iterations. */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_mul_core (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 start,
    input  wire logic [`MDU_XLEN-1:0] mag_a,
    input  wire logic [`MDU_XLEN-1:0] mag_b,
    input  wire logic                 word,
    output logic [2*`MDU_XLEN-1:0]    product,
    output logic                      done
);

    localparam int XLEN  = `MDU_XLEN;
    localparam int WLEN  = `MDU_WLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    logic              busy;
    logic [CNT_W-1:0]  count;
    logic [2*XLEN-1:0] acc;
    logic [2*XLEN-1:0] mcand;
    logic [XLEN-1:0]   mplier;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= word ? CNT_W'(WLEN) : CNT_W'(XLEN);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // The multiplicand moves left while the multiplier moves right, so the
    // low multiplier bit always picks the partial product of this step.
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= {{XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= {mcand[2*XLEN-2:0], 1'b0};
            mplier <= {1'b0, mplier[XLEN-1:1]};
        end
    end

    assign product = acc;

    // A new multiply may only begin once the previous one has signalled done.
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset) start |-> !busy
    );

endmodule

`default_nettype wire

/* logic/mdu_result_fmt.sv */
/* Result formatter: sign correction, high/low selection, division special
   cases and word sign extension. */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_result_fmt import mdu_pkg::*; (
    input  wire mdu_op_e              op,
    input  wire mdu_operands_t        opnd,
    input  wire logic [`MDU_XLEN-1:0]   quot,
    input  wire logic [`MDU_XLEN-1:0]   rem,
    input  wire logic [2*`MDU_XLEN-1:0] product,
    output logic [`MDU_XLEN-1:0]      result
);

    localparam int XLEN = `MDU_XLEN;
    localparam int WLEN = `MDU_WLEN;

    logic [2*XLEN-1:0] prod_s;
    logic [XLEN-1:0]   quot_s;
    logic [XLEN-1:0]   rem_s;
    logic [XLEN-1:0]   dividend;
    logic [XLEN-1:0]   ovf_quot;
    logic [XLEN-1:0]   raw;

    // The product is negated at full width so the high half is exact.
    assign prod_s   = opnd.neg_lo  ? (~product + 1'b1) : product;
    assign quot_s   = opnd.neg_lo  ? (~quot + 1'b1) : quot;
    assign rem_s    = opnd.neg_rem ? (~rem + 1'b1) : rem;
    assign dividend = opnd.neg_rem ? (~opnd.mag_a + 1'b1) : opnd.mag_a;

    // Most negative value at the operating width.
    assign ovf_quot = opnd.word ? {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}}
                                : {1'b1, {(XLEN-1){1'b0}}};

    always_comb begin
        unique case (op)
            OP_MUL, OP_MULW:
                raw = prod_s[XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU:
                raw = prod_s[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW: begin
                if (opnd.div_zero) begin
                    raw = '1;
                end else if (opnd.div_ovf) begin
                    raw = ovf_quot;
                end else begin
                    raw = quot_s;
                end
            end
            OP_REM, OP_REMU, OP_REMW, OP_REMUW: begin
                if (opnd.div_zero) begin
                    raw = dividend;
                end else if (opnd.div_ovf) begin
                    raw = '0;
                end else begin
                    raw = rem_s;
                end
            end
            default:
                raw = '0;
        endcase
    end

    assign result = opnd.word ? {{(XLEN-WLEN){raw[WLEN-1]}}, raw[WLEN-1:0]} : raw;

endmodule

`default_nettype wire

/* logic/mdu_top.sv */
/* Multiply/divide unit top: request capture, control FSM, core start
   and response register with back-pressure. */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_top import mdu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     req_valid,
    output logic          req_ready,
    input  wire mdu_req_t req,
    output logic          rsp_valid,
    input  wire logic     rsp_ready,
    output mdu_rsp_t      rsp
);

    localparam int XLEN = `MDU_XLEN;

    mdu_state_e        state;
    mdu_req_t          req_q;
    mdu_operands_t     opnd_c;
    mdu_operands_t     opnd_q;
    logic              is_mul;
    logic              mul_start;
    logic              div_start;
    logic              mul_done;
    logic              div_done;
    logic [XLEN-1:0]   quot;
    logic [XLEN-1:0]   rem;
    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   fmt_result;

    assign req_ready = (state == IDLE);

    always_comb begin
        unique case (req_q.op)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW: is_mul = 1'b1;
            default:                                       is_mul = 1'b0;
        endcase
    end

    mdu_operand_prep i_prep (
        .req  (req_q),
        .opnd (opnd_c)
    );

    mdu_div_core i_div (
        .clk   (clk),
        .reset (reset),
        .start (div_start),
        .mag_a (opnd_q.mag_a),
        .mag_b (opnd_q.mag_b),
        .word  (opnd_q.word),
        .quot  (quot),
        .rem   (rem),
        .done  (div_done)
    );

    mdu_mul_core i_mul (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .mag_a   (opnd_q.mag_a),
        .mag_b   (opnd_q.mag_b),
        .word    (opnd_q.word),
        .product (product),
        .done    (mul_done)
    );

    mdu_result_fmt i_fmt (
        .op      (req_q.op),
        .opnd    (opnd_q),
        .quot    (quot),
        .rem     (rem),
        .product (product),
        .result  (fmt_result)
    );

    // Start is registered on leaving PREP, so the core sees opnd_q already loaded.
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            rsp_valid <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= PREP;
                    end
                end
                PREP: begin
                    mul_start <= is_mul;
                    div_start <= !is_mul;
                    state     <= is_mul ? RUN_MUL : RUN_DIV;
                end
                RUN_MUL: begin
                    if (mul_done) begin
                        state <= FORMAT;
                    end
                end
                RUN_DIV: begin
                    if (div_done) begin
                        state <= FORMAT;
                    end
                end
                FORMAT: begin
                    rsp_valid <= 1'b1;
                    state     <= RESPOND;
                end
                RESPOND: begin
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == PREP) begin
            opnd_q <= opnd_c;
        end
        if (state == FORMAT) begin
            rsp.result <= fmt_result;
            rsp.tag    <= req_q.tag;
        end
    end

    // A held response keeps its payload until the handshake.
    a_rsp_stable: assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    );

    // One operation at a time.
    a_one_op: assert property (
        @(posedge clk) disable iff (reset) !(req_ready && rsp_valid)
    );

endmodule

`default_nettype wire

/* verif/mdu_ref_model.svh */
/* Reference model for the testbench: the RISC-V result of every RV64M
   operation, built on the simulator's own signed and unsigned arithmetic. */
`ifndef MDU_REF_MODEL_SVH
`define MDU_REF_MODEL_SVH

// Sign-extends a 32-bit word result to the full register width.
function automatic logic [63:0] sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

function automatic logic [63:0] ref_result(input mdu_op_e op, input logic [63:0] a,
                                           input logic [63:0] b);
    logic signed [127:0] wide_a;
    logic signed [127:0] wide_b;
    logic signed [127:0] prod;
    logic signed [63:0]  sa;
    logic signed [63:0]  sb;
    logic signed [31:0]  wa;
    logic signed [31:0]  wb;
    logic [31:0]         ua;
    logic [31:0]         ub;
    logic                ovf;
    logic                wovf;
    sa     = a;
    sb     = b;
    wa     = a[31:0];
    wb     = b[31:0];
    ua     = a[31:0];
    ub     = b[31:0];
    wide_a = sa;
    wide_b = sb;
    // The only quotients that do not fit, at full and at word width.
    ovf    = (a == 64'h8000_0000_0000_0000) && (b == '1);
    wovf   = (ua == 32'h8000_0000) && (ub == 32'hFFFF_FFFF);
    case (op)
        OP_MUL:
            return a * b;
        OP_MULH: begin
            prod = wide_a * wide_b;
            return prod[127:64];
        end
        OP_MULHSU: begin
            prod = wide_a * $signed({64'h0, b});
            return prod[127:64];
        end
        OP_MULHU: begin
            prod = {64'h0, a} * {64'h0, b};
            return prod[127:64];
        end
        OP_MULW:
            return sext_word(ua * ub);
        OP_DIV: begin
            if (b == '0)
                return '1;
            if (ovf)
                return a;
            return sa / sb;
        end
        OP_DIVU:
            return (b == '0) ? '1 : a / b;
        OP_REM: begin
            if (b == '0)
                return a;
            if (ovf)
                return '0;
            // Truncating division, so the remainder follows the dividend.
            return sa % sb;
        end
        OP_REMU:
            return (b == '0) ? a : a % b;
        OP_DIVW: begin
            if (ub == '0)
                return '1;
            if (wovf)
                return sext_word(ua);
            return sext_word(wa / wb);
        end
        OP_DIVUW:
            return (ub == '0) ? '1 : sext_word(ua / ub);
        OP_REMW: begin
            if (ub == '0)
                return sext_word(ua);
            if (wovf)
                return '0;
            return sext_word(wa % wb);
        end
        OP_REMUW:
            return (ub == '0) ? sext_word(ua) : sext_word(ua % ub);
        default:
            return '0;
    endcase
endfunction

`endif

/* verif/tb_mdu.sv */
/* Testbench for the multiply/divide unit: clock and reset, LFSR stimulus,
   request driver, response checker with back-pressure, closing summary. */
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module tb_mdu import mdu_pkg::*; ();

    localparam int          NUM_RANDOM = 400;
    localparam int          TIMEOUT    = 200;
    localparam logic [31:0] LFSR_MASK  = 32'h8020_0003;

    // A request together with the response the model predicts for it.
    typedef struct packed {
        mdu_req_t req;
        mdu_rsp_t rsp;
    } expect_t;

    logic     clk;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    mdu_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    mdu_rsp_t rsp;

    logic [31:0] lfsr_state;
    expect_t     expected_q[$];
    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    logic        aborted;

    `include "mdu_ref_model.svh"

    mdu_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois step; the bit shifted out is the random bit.
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_MASK;
        end
        return out;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_bit()};
        end
        return r;
    endfunction

    // Leans toward zero, minus one and the most negative value, at full or word width.
    function automatic logic [63:0] pick_operand();
        logic [1:0]  sel;
        logic        narrow;
        logic [63:0] val;
        sel    = 2'(random_bits(2));
        narrow = lfsr_bit();
        val    = random_bits(64);
        case (sel)
            2'd1: val = narrow ? {val[63:32], 32'h0} : '0;
            2'd2: val = narrow ? {val[63:32], 32'hFFFF_FFFF} : '1;
            2'd3: val = narrow ? {val[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
            default: ;
        endcase
        return val;
    endfunction

    task automatic check_response(input mdu_rsp_t got);
        expect_t exp;
        exp = expected_q.pop_front();
        assert (got.result === exp.rsp.result) else begin
            value_errors++;
            $display("Fail rsp.result: op 0x%0h rs1 0x%h rs2 0x%h, got 0x%h, expected 0x%h",
                     exp.req.op, exp.req.rs1, exp.req.rs2, got.result, exp.rsp.result);
        end
        assert (got.tag === exp.rsp.tag) else begin
            value_errors++;
            $display("Fail rsp.tag: got 0x%h, expected 0x%h", got.tag, exp.rsp.tag);
        end
    endtask

    // Sends one request, then follows its response through random back-pressure.
    task automatic run_op(input mdu_op_e op, input logic [63:0] a, input logic [63:0] b);
        int       waited;
        logic     seen;
        logic     taken;
        mdu_rsp_t held;
        expect_t  exp;
        if (aborted) return;
        @(negedge clk);
        req_valid = 1'b1;
        req.op    = op;
        req.rs1   = a;
        req.rs2   = b;
        req.tag   = `MDU_TAG_W'(random_bits(`MDU_TAG_W));
        waited    = 0;
        while (!req_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: the DUT did not accept a request within %0d cycles", TIMEOUT);
            return;
        end
        exp.req        = req;
        exp.rsp.result = ref_result(op, a, b);
        exp.rsp.tag    = req.tag;
        expected_q.push_back(exp);
        // The transfer happened on the rising edge; the operands must be held inside.
        @(negedge clk);
        req_valid = 1'b0;
        req.rs1   = ~a;
        req.rs2   = ~b;
        req.tag   = ~req.tag;
        waited    = 0;
        seen      = 1'b0;
        taken     = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            rsp_ready = lfsr_bit();
            assert (!req_ready) else begin
                protocol_errors++;
                $display("req_ready went high before the response was accepted");
            end
            if (rsp_valid) begin
                if (seen) begin
                    assert (rsp === held) else begin
                        protocol_errors++;
                        $display("Fail rsp under back-pressure: got 0x%h, held 0x%h", rsp, held);
                    end
                end
                held  = rsp;
                seen  = 1'b1;
                taken = rsp_ready;
            end
            if (!taken) begin
                @(negedge clk);
                waited++;
            end
        end
        if (!taken) begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: no response was accepted within %0d cycles", TIMEOUT);
            return;
        end
        check_response(rsp);
        @(negedge clk);
        rsp_ready = 1'b0;
        assert (!rsp_valid && req_ready) else begin
            protocol_errors++;
            $display("The DUT did not return to idle after the response handshake");
        end
    endtask

    // Division by zero at both widths, signed overflow and extreme products.
    task automatic run_directed();
        mdu_op_e     div_ops[8];
        logic [63:0] a;
        logic [31:0] hi;
        div_ops = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
        foreach (div_ops[i]) begin
            a  = random_bits(64);
            hi = 32'(random_bits(32));
            run_op(div_ops[i], a, 64'h0);
            run_op(div_ops[i], a, {hi, 32'h0});
        end
        hi = 32'(random_bits(32));
        run_op(OP_DIV, 64'h8000_0000_0000_0000, '1);
        run_op(OP_REM, 64'h8000_0000_0000_0000, '1);
        run_op(OP_DIVW, {hi, 32'h8000_0000}, {~hi, 32'hFFFF_FFFF});
        run_op(OP_REMW, {hi, 32'h8000_0000}, {~hi, 32'hFFFF_FFFF});
        run_op(OP_MULH, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
        run_op(OP_MULHSU, 64'h8000_0000_0000_0000, '1);
        run_op(OP_MULHU, '1, '1);
    endtask

    initial begin
        mdu_op_e     op;
        logic [63:0] a;
        logic [63:0] b;
        lfsr_state      = 32'd22149;
        reset           = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        rsp_ready       = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        aborted         = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (!rsp_valid && req_ready) else begin
            protocol_errors++;
            $display("After reset rsp_valid is not low or req_ready is not high");
        end
        run_directed();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            op = mdu_op_e'(4'(random_bits(4) % 13));
            a  = pick_operand();
            b  = pick_operand();
            run_op(op, a, b);
        end
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
+incdir+verif
logic/mdu_pkg.sv
logic/mdu_operand_prep.sv
logic/mdu_div_core.sv
logic/mdu_mul_core.sv
logic/mdu_result_fmt.sv
logic/mdu_top.sv
verif/tb_mdu.sv
